//--- src.f
+incdir+hdl
hdl/pp_pkg.sv
hdl/bias_scale_stage.sv
hdl/relu_quant_lane.sv
hdl/quant_beat_packer.sv
hdl/psum_postproc_top.sv
sim/psum_postproc_props.sv
sim/psum_postproc_tb.sv

//--- Bender.yml
package:
  name: psum_postproc

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pp_pkg.sv
      - hdl/bias_scale_stage.sv
      - hdl/relu_quant_lane.sv
      - hdl/quant_beat_packer.sv
      - hdl/psum_postproc_top.sv

  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/psum_postproc_props.sv
      - sim/psum_postproc_tb.sv

//--- sim/psum_postproc_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "pp_defines.svh"

module psum_postproc_tb;

  import pp_pkg::*;

  localparam int BEAT_W  = `PP_BEAT_LANES * `PP_PIX_W;
  localparam int TIMEOUT = 64;

  logic     clk = 1'b0;
  logic     arst_n;
  logic     acc_valid;
  pp_mode_e mode;
  scale_t   scale_set  [`PP_CH_NUM];
  bias_t    bias_set   [`PP_CH_NUM];
  acc_t     acc_vector [`PP_LANES];
  logic     out_valid;
  pix_t     out_data   [`PP_BEAT_LANES];
  logic     out_last;
  logic     overrun;

  int          cyc = 0;
  logic [31:0] lfsr = 32'd75091;

  // expected beats in arrival order
  logic [BEAT_W-1:0] exp_data_q [$];
  logic              exp_last_q [$];
  int                exp_cyc_q  [$];

  psum_postproc_top uut (
    .clk        (clk),
    .arst_n     (arst_n),
    .acc_valid  (acc_valid),
    .mode       (mode),
    .scale_set  (scale_set),
    .bias_set   (bias_set),
    .acc_vector (acc_vector),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_last   (out_last),
    .overrun    (overrun)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////
  // random source and model
  //////////////////////////////

  // taps 32, 22, 2, 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic longint rand_bits(input int n);
    longint v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | longint'(lfsr_step());
    end
    return v;
  endfunction

  function automatic longint rand_signed(input int n);
    longint v;
    v = rand_bits(n);
    if (v[n-1]) begin
      v = v - (longint'(1) << n);
    end
    return v;
  endfunction

  // bias first, then relu, shift and clamp
  function automatic pix_t model_pix(input acc_t acc, input bias_t bias, input scale_t sc);
    longint s;
    s = longint'(acc) + longint'(bias);
    if (s < 0 || sc > 62) begin
      return '0;
    end
    s = s >>> sc;
    return (s > 255) ? pix_t'(255) : pix_t'(s);
  endfunction

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_pix(input pix_t act, input pix_t exp, input string what);
    if (act !== exp) begin
      report_error($sformatf("FAIL %0t: %s is %0d, expected %0d", $time, what, act, exp));
    end
  endtask

  task automatic check_beat(input pix_t act [`PP_BEAT_LANES],
                            input pix_t exp [`PP_BEAT_LANES], input string what);
    for (int k = 0; k < `PP_BEAT_LANES; k++) begin
      check_pix(act[k], exp[k], $sformatf("%s lane %0d", what, k));
    end
  endtask

  task automatic check_flag(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      report_error($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, act, exp));
    end
  endtask

  // outputs are compared mid-cycle
  always @(negedge clk) begin : beat_monitor
    pix_t              exp_beat [`PP_BEAT_LANES];
    logic [BEAT_W-1:0] exp_vec;
    if (arst_n && exp_cyc_q.size() > 0 && exp_cyc_q[0] == cyc) begin
      exp_vec = exp_data_q.pop_front();
      for (int k = 0; k < `PP_BEAT_LANES; k++) begin
        exp_beat[k] = exp_vec[k*`PP_PIX_W +: `PP_PIX_W];
      end
      void'(exp_cyc_q.pop_front());
      check_flag(out_valid, 1'b1, $sformatf("out_valid in cycle %0d", cyc));
      check_flag(out_last, exp_last_q.pop_front(), $sformatf("out_last in cycle %0d", cyc));
      check_beat(out_data, exp_beat, $sformatf("out_data in cycle %0d", cyc));
    end else if (arst_n && out_valid) begin
      report_error($sformatf("a beat came out in cycle %0d with no vector to account for it",
                             cyc));
    end
  end

  always @(negedge clk) begin
    if (uut.u_props.fail_cnt != 0) begin
      report_error("a bound timing assertion failed");
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  task automatic fill_random();
    for (int i = 0; i < `PP_LANES; i++) begin
      acc_vector[i] = acc_t'(rand_signed(14));
    end
    for (int c = 0; c < `PP_CH_NUM; c++) begin
      bias_set[c]  = bias_t'(rand_signed(10));
      scale_set[c] = scale_t'(rand_bits(2) + 3);
    end
  endtask

  // strobe sampled at edge N, first beat seen after edge N+2
  task automatic send_vector(input pp_mode_e m, input bit expect_beats);
    int                n_beats;
    int                lane;
    int                ch;
    logic [BEAT_W-1:0] beat;
    n_beats = ((m == MODE_18) ? `PP_LANES : `PP_CH_LANES) / `PP_BEAT_LANES;
    @(posedge clk);
    #1;
    mode      = m;
    acc_valid = 1'b1;
    for (int b = 0; expect_beats && b < n_beats; b++) begin
      for (int k = 0; k < `PP_BEAT_LANES; k++) begin
        lane = b * `PP_BEAT_LANES + k;
        ch   = (m == MODE_18 && lane >= `PP_CH_LANES) ? 1 : 0;
        beat[k*`PP_PIX_W +: `PP_PIX_W] =
          model_pix(acc_vector[lane], bias_set[ch], scale_set[ch]);
      end
      exp_data_q.push_back(beat);
      exp_last_q.push_back(b == n_beats - 1);
      exp_cyc_q.push_back(cyc + 3 + b);
    end
    @(posedge clk);
    #1;
    acc_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_cyc_q.size() > 0) begin
      if (n == TIMEOUT) begin
        report_error("timed out waiting for the expected output beats");
      end else begin
        @(negedge clk);
        n++;
      end
    end
    // quiet cycles so stray beats get caught
    repeat (6) @(posedge clk);
    #1;
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_reset_state();
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_flag(out_valid, 1'b0, "out_valid after reset");
      check_flag(out_last, 1'b0, "out_last after reset");
      check_flag(overrun, 1'b0, "overrun after reset");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic test_mode88_random();
    repeat (4) begin
      fill_random();
      send_vector(MODE_88, 1'b1);
      wait_drained();
    end
  endtask

  task automatic test_mode18_dual();
    repeat (4) begin
      fill_random();
      scale_set[1] = scale_set[0] + 8'd2;
      bias_set[1]  = bias_set[0] - 32'sd611;
      send_vector(MODE_18, 1'b1);
      wait_drained();
    end
  endtask

  task automatic test_edge_values();
    fill_random();
    scale_set[0]  = 8'd0;
    bias_set[0]   = 32'sd0;
    acc_vector[0] = -40'sd5;
    acc_vector[1] = 40'sd200;
    acc_vector[2] = 40'sd1000;
    acc_vector[3] = acc_t'({1'b0, {(`PP_ACC_W-1){1'b1}}});
    acc_vector[4] = acc_t'({1'b1, {(`PP_ACC_W-1){1'b0}}});
    // shift past the sum width
    scale_set[1]   = 8'd45;
    bias_set[1]    = 32'sd1000;
    acc_vector[32] = acc_t'({1'b0, {(`PP_ACC_W-1){1'b1}}});
    send_vector(MODE_18, 1'b1);
    wait_drained();
    // bias pushes sums across zero
    scale_set[0]   = 8'd1;
    bias_set[0]    = -32'sd100;
    acc_vector[0]  = 40'sd50;
    acc_vector[1]  = 40'sd150;
    scale_set[1]   = 8'd2;
    bias_set[1]    = 32'sd300;
    acc_vector[32] = -40'sd200;
    acc_vector[33] = acc_t'({1'b0, {(`PP_ACC_W-1){1'b1}}});
    send_vector(MODE_18, 1'b1);
    wait_drained();
  endtask

  task automatic test_back_to_back();
    for (int i = 0; i < 5; i++) begin
      fill_random();
      send_vector(MODE_18, 1'b1);
      repeat (2) @(posedge clk);
      #1;
    end
    wait_drained();
    for (int i = 0; i < 5; i++) begin
      fill_random();
      send_vector(MODE_88, 1'b1);
    end
    wait_drained();
    check_flag(overrun, 1'b0, "overrun after spaced strobes");
  endtask

  task automatic test_overrun();
    fill_random();
    send_vector(MODE_18, 1'b1);
    fill_random();
    // lands while the first vector is mid-emission
    send_vector(MODE_18, 1'b0);
    wait_drained();
    check_flag(overrun, 1'b1, "overrun after dropped vector");
    repeat (8) @(posedge clk);
    #1;
    check_flag(overrun, 1'b1, "overrun held");
  endtask

  initial begin
    arst_n    = 1'b1;
    acc_valid = 1'b0;
    mode      = MODE_88;
    for (int c = 0; c < `PP_CH_NUM; c++) begin
      scale_set[c] = '0;
      bias_set[c]  = '0;
    end
    for (int i = 0; i < `PP_LANES; i++) begin
      acc_vector[i] = '0;
    end
    #1;
    arst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;

    test_reset_state();
    test_mode88_random();
    test_mode18_dual();
    test_edge_values();
    test_back_to_back();
    test_overrun();

    if (uut.u_props.fail_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1, "a bound timing assertion failed");
    end
  end

endmodule

`default_nettype wire

//--- sim/psum_postproc_props.sv
`timescale 1ns/100ps
`default_nettype none

module psum_postproc_props (
  input logic clk,
  input logic arst_n,
  input logic acc_valid,
  input logic out_valid,
  input logic out_last,
  input logic overrun
);

  // bumped by every failing assertion
  int fail_cnt = 0;

  last_with_valid: assert property (
    @(posedge clk) disable iff (!arst_n) out_last |-> out_valid
  ) else begin
    $error("out_last raised without out_valid");
    fail_cnt++;
  end

  // a beat that opens a vector traces back to a strobe
  first_beat_latency: assert property (
    @(posedge clk) disable iff (!arst_n)
    (out_valid && !$past(out_valid && !out_last)) |-> $past(acc_valid, 3)
  ) else begin
    $error("first beat without a strobe three cycles earlier");
    fail_cnt++;
  end

  // packer free when the vector reaches it, so it is accepted
  strobe_gives_beat: assert property (
    @(posedge clk) disable iff (!arst_n)
    acc_valid ##2 (!out_valid || out_last) |=> out_valid
  ) else begin
    $error("accepted strobe gave no beat three cycles later");
    fail_cnt++;
  end

  overrun_sticky: assert property (
    @(posedge clk) disable iff (!arst_n) overrun |=> overrun
  ) else begin
    $error("overrun fell without reset");
    fail_cnt++;
  end

  valid_low_in_reset: assert property (
    @(posedge clk) !arst_n |-> !out_valid
  ) else begin
    $error("out_valid high during reset");
    fail_cnt++;
  end

endmodule

bind psum_postproc_top psum_postproc_props u_props (
  .clk       (clk),
  .arst_n    (arst_n),
  .acc_valid (acc_valid),
  .out_valid (out_valid),
  .out_last  (out_last),
  .overrun   (overrun)
);

`default_nettype wire

//--- hdl/psum_postproc_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "pp_defines.svh"

module psum_postproc_top (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             acc_valid,
  input  pp_pkg::pp_mode_e mode,
  input  pp_pkg::scale_t   scale_set  [`PP_CH_NUM],
  input  pp_pkg::bias_t    bias_set   [`PP_CH_NUM],
  input  pp_pkg::acc_t     acc_vector [`PP_LANES],
  output logic             out_valid,
  output pp_pkg::pix_t     out_data   [`PP_BEAT_LANES],
  output logic             out_last,
  output logic             overrun
);

  import pp_pkg::*;

  logic     stg_valid;
  pp_mode_e stg_mode;
  sum_t     stg_sum   [`PP_LANES];
  scale_t   stg_shift [`PP_LANES];
  logic     lane_valid;
  pix_t     lane_pix  [`PP_LANES];

  bias_scale_stage u_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .acc_valid  (acc_valid),
    .mode       (mode),
    .scale_set  (scale_set),
    .bias_set   (bias_set),
    .acc_vector (acc_vector),
    .stg_valid  (stg_valid),
    .stg_mode   (stg_mode),
    .stg_sum    (stg_sum),
    .stg_shift  (stg_shift)
  );

  // lane 0 valid stands for all lanes
  for (genvar i = 0; i < `PP_LANES; i++) begin : g_lane
    if (i == 0) begin : g_first
      relu_quant_lane u_lane (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (stg_valid),
        .sum       (stg_sum[i]),
        .shift     (stg_shift[i]),
        .out_valid (lane_valid),
        .pix       (lane_pix[i])
      );
    end else begin : g_rest
      relu_quant_lane u_lane (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (stg_valid),
        .sum       (stg_sum[i]),
        .shift     (stg_shift[i]),
        .out_valid (),
        .pix       (lane_pix[i])
      );
    end
  end

  quant_beat_packer u_packer (
    .clk        (clk),
    .arst_n     (arst_n),
    .lane_valid (lane_valid),
    .mode       (stg_mode),
    .lane_pix   (lane_pix),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .out_data   (out_data),
    .overrun    (overrun)
  );

endmodule

`default_nettype wire

//--- hdl/quant_beat_packer.sv
`timescale 1ns/100ps
`default_nettype none

`include "pp_defines.svh"

module quant_beat_packer (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             lane_valid,
  input  pp_pkg::pp_mode_e mode,
  input  pp_pkg::pix_t     lane_pix [`PP_LANES],
  output logic             out_valid,
  output logic             out_last,
  output pp_pkg::pix_t     out_data [`PP_BEAT_LANES],
  output logic             overrun
);

  import pp_pkg::*;

  localparam int CNT_W = $clog2(`PP_MAX_BEATS);

  // final beat index per mode
  localparam logic [CNT_W-1:0] LAST_88 = CNT_W'(`PP_CH_LANES / `PP_BEAT_LANES - 1);
  localparam logic [CNT_W-1:0] LAST_18 = CNT_W'(`PP_LANES / `PP_BEAT_LANES - 1);

  pp_mode_e         mode_d;
  logic [CNT_W-1:0] beat_cnt;
  logic [CNT_W-1:0] last_beat;
  logic             beats_left;
  logic             accept;
  pix_t             pix_buf [`PP_LANES];

  // still emitting and not yet on the final beat
  assign beats_left = out_valid && (beat_cnt != last_beat);
  assign accept     = lane_valid && !beats_left;

  //////////////////////////////
  // beat control
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mode_d    <= MODE_88;
      out_valid <= 1'b0;
      beat_cnt  <= '0;
      last_beat <= LAST_88;
      overrun   <= 1'b0;
    end else begin
      // stage mode lines up with lane_valid one cycle later
      mode_d <= mode;
      if (accept) begin
        out_valid <= 1'b1;
        beat_cnt  <= '0;
        last_beat <= (mode_d == MODE_18) ? LAST_18 : LAST_88;
      end else if (out_valid) begin
        if (beat_cnt == last_beat) begin
          out_valid <= 1'b0;
        end else begin
          beat_cnt <= beat_cnt + 1'b1;
        end
      end
      // sticky until reset
      if (lane_valid && beats_left) begin
        overrun <= 1'b1;
      end
    end
  end

  // captured vector
  always_ff @(posedge clk) begin
    if (accept) begin
      pix_buf <= lane_pix;
    end
  end

  //////////////////////////////
  // beat slicing
  //////////////////////////////

  always_comb begin
    for (int k = 0; k < `PP_BEAT_LANES; k++) begin
      out_data[k] = pix_buf[int'(beat_cnt) * `PP_BEAT_LANES + k];
    end
  end

  assign out_last = out_valid && (beat_cnt == last_beat);

endmodule

`default_nettype wire

//--- hdl/relu_quant_lane.sv
`timescale 1ns/100ps
`default_nettype none

`include "pp_defines.svh"

module relu_quant_lane (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           in_valid,
  input  pp_pkg::sum_t   sum,
  input  pp_pkg::scale_t shift,
  output logic           out_valid,
  output pp_pkg::pix_t   pix
);

  import pp_pkg::*;

  sum_t shifted;
  pix_t pix_nxt;

  // only taken when sum is non-negative, so zero fill is fine
  assign shifted = sum >> shift;

  always_comb begin
    if (sum[`PP_ACC_W]) begin
      // relu
      pix_nxt = '0;
    end else if (|shifted[`PP_ACC_W:`PP_PIX_W]) begin
      // saturate at 255
      pix_nxt = '1;
    end else begin
      pix_nxt = shifted[`PP_PIX_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      pix <= pix_nxt;
    end
  end

endmodule

`default_nettype wire

//--- hdl/bias_scale_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "pp_defines.svh"

module bias_scale_stage (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              acc_valid,
  input  pp_pkg::pp_mode_e  mode,
  input  pp_pkg::scale_t    scale_set  [`PP_CH_NUM],
  input  pp_pkg::bias_t     bias_set   [`PP_CH_NUM],
  input  pp_pkg::acc_t      acc_vector [`PP_LANES],
  output logic              stg_valid,
  output pp_pkg::pp_mode_e  stg_mode,
  output pp_pkg::sum_t      stg_sum    [`PP_LANES],
  output pp_pkg::scale_t    stg_shift  [`PP_LANES]
);

  import pp_pkg::*;

  // channel index per lane
  logic   ch_idx    [`PP_LANES];
  sum_t   sum_nxt   [`PP_LANES];
  scale_t shift_nxt [`PP_LANES];

  //////////////////////////////
  // channel select and bias add
  //////////////////////////////

  for (genvar i = 0; i < `PP_LANES; i++) begin : g_lane_sel
    // upper half follows channel 1 only in dual mode
    assign ch_idx[i] = (mode == MODE_18) && (i >= `PP_CH_LANES);

    // both operands sign extended to the sum width
    assign sum_nxt[i] = sum_t'(acc_vector[i]) + sum_t'(bias_set[ch_idx[i]]);

    assign shift_nxt[i] = scale_set[ch_idx[i]];
  end

  //////////////////////////////
  // stage registers
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stg_valid <= 1'b0;
      stg_mode  <= MODE_88;
    end else begin
      stg_valid <= acc_valid;
      // mode rides along so the packer knows the beat count
      if (acc_valid) begin
        stg_mode <= mode;
      end
    end
  end

  // payload, loaded on the strobe only
  always_ff @(posedge clk) begin
    if (acc_valid) begin
      stg_sum   <= sum_nxt;
      stg_shift <= shift_nxt;
    end
  end

endmodule

`default_nettype wire

//--- hdl/pp_pkg.sv
`default_nettype none

`include "pp_defines.svh"

package pp_pkg;

  // accumulated product of one lane
  typedef logic signed [`PP_ACC_W-1:0] acc_t;

  // per-channel bias
  typedef logic signed [`PP_BIAS_W-1:0] bias_t;

  // one extra bit so acc + bias never wraps
  typedef logic signed [`PP_ACC_W:0] sum_t;

  // right-shift amount, anything past the sum width gives 0
  typedef logic [`PP_SCALE_W-1:0] scale_t;

  // quantized pixel
  typedef logic [`PP_PIX_W-1:0] pix_t;

  // 88 is one channel over the low half, 18 is two channels
  typedef enum logic {
    MODE_88 = 1'b0,
    MODE_18 = 1'b1
  } pp_mode_e;

endpackage

`default_nettype wire

//--- hdl/pp_defines.svh
`ifndef PP_DEFINES_SVH
`define PP_DEFINES_SVH

//////////////////////////////
// array geometry
//////////////////////////////

`define PP_COLS 16
// pixels per column per channel
`define PP_PIX_PAR 2
`define PP_CH_NUM 2
`define PP_CH_LANES (`PP_COLS * `PP_PIX_PAR)
`define PP_LANES (`PP_CH_NUM * `PP_CH_LANES)

// field widths
`define PP_ACC_W 40
`define PP_BIAS_W 32
`define PP_SCALE_W 8
`define PP_PIX_W 8

// one beat carries 16 pixels, i.e. 128 bits
`define PP_BEAT_LANES 16
`define PP_MAX_BEATS (`PP_LANES / `PP_BEAT_LANES)

`endif
